/* compile.f */
cart_pkg.sv
msx_bus_if.sv
vdp_port.sv
vram_ctrl.sv
cart_top.sv
cart_checker.sv
tb_cart.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the cartridge testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module tb_cart \
	-f compile.f \
	-o sim_cart

./obj_dir/sim_cart

/* tb_cart.sv */
`default_nettype none

module tb_cart import cart_pkg::*; ();

	localparam int VRAM_AW = 14;
	localparam int REFRESH_PERIOD = 64;
	// Bus cycle shape in clk cycles
	localparam int HOLD = 12;
	localparam int GAP = 3;
	localparam int BURST = 32;
	// Random reads stay inside this pre-filled window
	localparam int FILL_LEN = 256;
	localparam int NUM_STRESS = 300;
	// Upper bound on bus cycles over all tests
	localparam int OP_COUNT = FILL_LEN + 3 + 2 * BURST + 100 + 4 * NUM_STRESS;
	localparam int CYCLE_LIMIT = OP_COUNT * 40 + 1000;
	// Start 16 bytes below the top so bursts wrap
	localparam logic [15:0] TOP_ADDR = 16'((1 << VRAM_AW) - 16);

	logic clk;
	logic rst;
	logic n_ioreq;
	logic n_rd;
	logic n_wr;
	logic [1:0] ta;
	logic [7:0] td_in;
	logic [7:0] td_out;
	logic tdir;
	logic twait;

	// ------------------------------
	// Model state
	// ------------------------------
	logic [7:0] m_vram [2**VRAM_AW];
	logic [7:0] m_regs [NUM_REGS];
	logic [VRAM_AW-1:0] m_addr;
	logic [7:0] m_buf;
	logic [7:0] m_latch;
	// Value last driven on td_out
	logic [7:0] m_last;
	logic m_flag;
	logic [2:0] m_ptr;

	logic [31:0] rng;
	// Sampled and expected read bytes
	logic [7:0] got_q [$];
	logic [7:0] exp_q [$];
	logic [7:0] cmp_got;
	logic [7:0] cmp_exp;
	int cycle_cnt = 0;

	cart_top #(.VRAM_AW(VRAM_AW), .REFRESH_PERIOD(REFRESH_PERIOD)) uut (
		.clk(clk), .rst(rst),
		.n_ioreq(n_ioreq), .n_rd(n_rd), .n_wr(n_wr),
		.ta(ta), .td_in(td_in),
		.td_out(td_out), .tdir(tdir), .twait(twait)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("tests failed");
		$fatal(1, "simulation stopped on error");
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_rand();
		rng = xorshift32(rng);
		return rng;
	endfunction

	// Returns the expected byte for a read and advances the model
	function automatic logic [7:0] expected_read(input logic [1:0] p);
		logic [7:0] r;
		r = m_last;
		case (p)
			PORT_DATA: begin
				// Old buffer goes out and refills from the current address
				r = m_buf;
				m_buf = m_vram[m_addr];
				m_addr = m_addr + 1'b1;
				m_flag = 1'b0;
			end
			PORT_CTRL: begin
				r = {7'b0, m_flag};
				m_flag = 1'b0;
			end
			PORT_REGR: r = m_regs[m_ptr];
			// Port 2 reads leave td_out as it was
			default: r = m_last;
		endcase
		m_last = r;
		return r;
	endfunction

	function automatic void apply_write(input logic [1:0] p, input logic [7:0] d);
		logic [15:0] a;
		a = {2'b00, d[5:0], m_latch};
		case (p)
			PORT_DATA: begin
				m_vram[m_addr] = d;
				m_addr = m_addr + 1'b1;
				m_flag = 1'b0;
			end
			PORT_CTRL: begin
				if (!m_flag) begin
					m_latch = d;
					m_flag = 1'b1;
				end else begin
					m_flag = 1'b0;
					if (d[7]) begin
						// Register 7 is the pointer
						if (d[2:0] == 3'd7)
							m_ptr = m_latch[2:0];
						else
							m_regs[d[2:0]] = m_latch;
					end else if (d[6]) begin
						m_addr = a[VRAM_AW-1:0];
					end else begin
						m_buf = m_vram[a[VRAM_AW-1:0]];
						m_addr = a[VRAM_AW-1:0] + 1'b1;
					end
				end
			end
			PORT_REGW: begin
				m_regs[m_ptr] = d;
				m_ptr = m_ptr + 1'b1;
			end
			default: ;
		endcase
	endfunction

	// ------------------------------
	// Bus cycles
	// ------------------------------
	task automatic write_port(input logic [1:0] p, input logic [7:0] d);
		apply_write(p, d);
		@(posedge clk);
		ta <= p;
		td_in <= d;
		n_ioreq <= 1'b0;
		n_wr <= 1'b0;
		repeat (HOLD) @(posedge clk);
		n_ioreq <= 1'b1;
		n_wr <= 1'b1;
		repeat (GAP) @(posedge clk);
	endtask

	task automatic read_and_check(input logic [1:0] p);
		logic [7:0] want;
		want = expected_read(p);
		@(posedge clk);
		ta <= p;
		n_ioreq <= 1'b0;
		n_rd <= 1'b0;
		repeat (HOLD) @(posedge clk);
		// CPU stretches the cycle while twait is up
		@(negedge clk);
		while (twait)
			@(negedge clk);
		assert (tdir === 1'b1)
		else fail_run($sformatf("FAILED tdir expected %h actual %h", 1'b1, tdir));
		got_q.push_back(td_out);
		exp_q.push_back(want);
		@(posedge clk);
		n_ioreq <= 1'b1;
		n_rd <= 1'b1;
		repeat (GAP) @(posedge clk);
		@(negedge clk);
		assert (tdir === 1'b0)
		else fail_run($sformatf("FAILED tdir expected %h actual %h", 1'b0, tdir));
	endtask

	// Second byte bit 6 picks write setup
	task automatic set_address(input logic [15:0] a, input logic write_mode);
		write_port(PORT_CTRL, a[7:0]);
		write_port(PORT_CTRL, {1'b0, write_mode, a[13:8]});
	endtask

	task automatic load_register(input logic [2:0] idx, input logic [7:0] val);
		write_port(PORT_CTRL, val);
		write_port(PORT_CTRL, {5'b10000, idx});
	endtask

	// Drop a pending first byte so the next pair lines up
	task automatic resync_control();
		if (m_flag)
			read_and_check(PORT_CTRL);
	endtask

	// ------------------------------
	// Compare and timeout
	// ------------------------------
	always @(posedge clk) begin
		if (exp_q.size() != 0) begin
			cmp_got = got_q.pop_front();
			cmp_exp = exp_q.pop_front();
			assert (cmp_got === cmp_exp)
			else fail_run($sformatf("FAILED td_out expected %h actual %h", cmp_exp, cmp_got));
		end
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT)
			fail_run("timeout, the run went past its cycle limit");
	end

	initial begin
		logic [31:0] r;
		int waited;
		int op;
		rst = 1'b1;
		n_ioreq = 1'b1;
		n_rd = 1'b1;
		n_wr = 1'b1;
		ta = 2'd0;
		td_in = 8'h00;
		rng = 32'h34d2;
		m_addr = '0;
		m_buf = 8'h00;
		m_latch = 8'h00;
		m_last = 8'h00;
		m_flag = 1'b0;
		m_ptr = 3'd0;
		for (int i = 0; i < NUM_REGS; i++)
			m_regs[i] = 8'h00;

		// Power-up wait
		repeat (3) @(posedge clk);
		@(negedge clk);
		assert (twait === 1'b1)
		else fail_run($sformatf("FAILED twait expected %h actual %h", 1'b1, twait));
		@(posedge clk);
		rst <= 1'b0;
		waited = 0;
		@(negedge clk);
		while (twait) begin
			assert (tdir === 1'b0)
			else fail_run($sformatf("FAILED tdir expected %h actual %h", 1'b0, tdir));
			waited++;
			@(negedge clk);
		end
		assert (waited >= POWERUP_WAIT - 2 && waited <= POWERUP_WAIT + 2)
		else fail_run($sformatf("twait stayed high %0d cycles after reset, not about %0d",
			waited, POWERUP_WAIT));

		// Known window plus the one byte a prefetch can reach past its end
		set_address(16'h0000, 1'b1);
		for (int i = 0; i <= FILL_LEN; i++) begin
			r = next_rand();
			write_port(PORT_DATA, r[7:0]);
		end

		// Burst across the top of VRAM
		set_address(TOP_ADDR, 1'b1);
		for (int i = 0; i < BURST; i++) begin
			r = next_rand();
			write_port(PORT_DATA, r[7:0]);
		end
		// Write setup leaves the old buffer for the first read
		set_address(TOP_ADDR, 1'b1);
		for (int i = 0; i <= BURST; i++)
			read_and_check(PORT_DATA);
		set_address(TOP_ADDR + 16'd14, 1'b0);
		for (int i = 0; i < 4; i++)
			read_and_check(PORT_DATA);

		// Registers written directly and then indirectly
		for (int i = 0; i < 7; i++) begin
			r = next_rand();
			load_register(3'(i), r[7:0]);
		end
		load_register(3'd7, 8'h05);
		for (int i = 0; i < 10; i++) begin
			r = next_rand();
			write_port(PORT_REGW, r[7:0]);
		end
		for (int i = 0; i < NUM_REGS; i++) begin
			load_register(3'd7, 8'(i));
			read_and_check(PORT_REGR);
		end
		// Pointer does not move on readback
		read_and_check(PORT_REGR);

		// Latch flag
		write_port(PORT_CTRL, 8'h5A);
		read_and_check(PORT_CTRL);
		read_and_check(PORT_CTRL);
		write_port(PORT_CTRL, 8'hA5);
		r = next_rand();
		write_port(PORT_DATA, r[7:0]);
		read_and_check(PORT_CTRL);
		set_address(16'h0020, 1'b0);
		write_port(PORT_CTRL, 8'h33);
		read_and_check(PORT_DATA);
		read_and_check(PORT_CTRL);

		// ------------------------------
		// Random mix over all ports
		// ------------------------------
		for (int n = 0; n < NUM_STRESS; n++) begin
			r = next_rand();
			op = int'(r[15:8]) % 10;
			case (op)
				0: write_port(PORT_DATA, r[7:0]);
				1, 2: begin
					// Prefetch must land inside the filled window
					if (int'(m_addr) < FILL_LEN) begin
						read_and_check(PORT_DATA);
					end else begin
						resync_control();
						set_address({8'h00, r[7:0]}, 1'b0);
						read_and_check(PORT_DATA);
					end
				end
				3: begin
					resync_control();
					set_address({8'h00, r[23:16]}, 1'b0);
					read_and_check(PORT_DATA);
				end
				4: begin
					resync_control();
					set_address(r[31:16], 1'b1);
				end
				5: begin
					resync_control();
					load_register(r[18:16], r[7:0]);
				end
				6: write_port(PORT_REGW, r[7:0]);
				7: read_and_check(PORT_REGR);
				8: read_and_check(PORT_CTRL);
				default: begin
					// Only ever a lone first byte here
					if (m_flag)
						read_and_check(PORT_CTRL);
					else
						write_port(PORT_CTRL, r[7:0]);
				end
			endcase
		end

		repeat (4) @(posedge clk);
		if (exp_q.size() == 0) begin
			$display("all tests passed");
			$finish;
		end else begin
			fail_run("reads were left unchecked at the end of the run");
		end
	end

endmodule

`default_nettype wire

/* cart_checker.sv */
`default_nettype none

module cart_checker import cart_pkg::*; #(
	parameter int REFRESH_PERIOD = 64
) (
	input wire clk,
	input wire rst,
	input wire req,
	input wire req_we,
	input wire start,
	input wire [1:0] count,
	input wire rd_valid
);

	// Reads accepted but not yet returned
	logic [2:0] ff_reads;
	// Cycles since reset give the refresh phase
	logic [31:0] ff_cycles;

	always_ff @(posedge clk) begin
		if (rst) begin
			ff_reads <= '0;
			ff_cycles <= '0;
		end else begin
			ff_reads <= ff_reads + 3'(req && !req_we) - 3'(rd_valid);
			ff_cycles <= ff_cycles + 1'b1;
		end
	end

	// ------------------------------
	// Queue depth
	// ------------------------------
	queue_depth: assert property (@(posedge clk) disable iff (rst) count != 2'd3)
		else $error("VRAM request queue holds more than two entries");

	// Full queue only takes a request if the head leaves
	queue_full: assert property (@(posedge clk) disable iff (rst)
		(count == 2'd2 && req) |-> start)
		else $error("VRAM request queue overflow");

	// Read data only for a read in flight
	read_owed: assert property (@(posedge clk) disable iff (rst)
		rd_valid |-> ff_reads != 3'd0)
		else $error("rd_valid with no read outstanding");

	// Window opens at the start of each period after reset
	refresh_idle: assert property (@(posedge clk) disable iff (rst)
		start |-> (ff_cycles % REFRESH_PERIOD) >= REFRESH_LEN)
		else $error("request started inside a refresh window");

endmodule

bind vram_ctrl cart_checker #(.REFRESH_PERIOD(REFRESH_PERIOD)) u_checker (
	.clk(clk), .rst(rst),
	.req(req), .req_we(req_we), .start(start),
	.count(ff_count),
	.rd_valid(rd_valid)
);

`default_nettype wire

/* cart_top.sv */
`default_nettype none

module cart_top #(
	parameter int VRAM_AW = 14,
	parameter int REFRESH_PERIOD = 64
) (
	input wire clk,
	input wire rst,
	input wire n_ioreq,
	input wire n_rd,
	input wire n_wr,
	input wire [1:0] ta,
	input wire [7:0] td_in,
	output logic [7:0] td_out,
	output logic tdir,
	output logic twait
);

	// Bus side to port block
	logic io_read;
	logic io_write;
	logic [1:0] port;
	logic [7:0] wdata;
	logic [7:0] rdata;
	logic fetch_pending;
	// Port block to VRAM
	logic req;
	logic req_we;
	logic [VRAM_AW-1:0] req_addr;
	logic [7:0] req_wdata;
	logic rd_valid;
	logic [7:0] rd_data;

	// ------------------------------
	// Cartridge bus
	// ------------------------------
	msx_bus_if u_bus (
		.clk(clk), .rst(rst),
		.n_ioreq(n_ioreq), .n_rd(n_rd), .n_wr(n_wr),
		.ta(ta), .td_in(td_in),
		.rdata(rdata), .fetch_pending(fetch_pending),
		.io_read(io_read), .io_write(io_write),
		.port(port), .wdata(wdata),
		.td_out(td_out), .tdir(tdir), .twait(twait)
	);

	// VDP I/O ports
	vdp_port #(.VRAM_AW(VRAM_AW)) u_vdp (
		.clk(clk), .rst(rst),
		.io_read(io_read), .io_write(io_write),
		.port(port), .wdata(wdata),
		.rd_valid(rd_valid), .rd_data(rd_data),
		.rdata(rdata), .fetch_pending(fetch_pending),
		.req(req), .req_we(req_we),
		.req_addr(req_addr), .req_wdata(req_wdata)
	);

	// VRAM with refresh stalls
	vram_ctrl #(.VRAM_AW(VRAM_AW), .REFRESH_PERIOD(REFRESH_PERIOD)) u_vram (
		.clk(clk), .rst(rst),
		.req(req), .req_we(req_we),
		.req_addr(req_addr), .req_wdata(req_wdata),
		.rd_valid(rd_valid), .rd_data(rd_data)
	);

endmodule

`default_nettype wire

/* vram_ctrl.sv */
`default_nettype none

module vram_ctrl import cart_pkg::*; #(
	parameter int VRAM_AW = 14,
	parameter int REFRESH_PERIOD = 64
) (
	input wire clk,
	input wire rst,
	input wire req,
	input wire req_we,
	input wire [VRAM_AW-1:0] req_addr,
	input wire [7:0] req_wdata,
	output logic rd_valid,
	output logic [7:0] rd_data
);

	localparam int RC_W = $clog2(REFRESH_PERIOD);

	// Two-entry request queue
	logic ff_q_we [2];
	logic [VRAM_AW-1:0] ff_q_addr [2];
	logic [7:0] ff_q_wdata [2];
	logic ff_wr_ptr;
	logic ff_rd_ptr;
	logic [1:0] ff_count;

	logic [RC_W-1:0] ff_ref_cnt;
	logic refresh_active;
	logic start;

	logic [7:0] mem [2**VRAM_AW];
	// Read delay line for valid and data
	logic [READ_LATENCY-1:0] ff_vpipe;
	logic [7:0] ff_dpipe [READ_LATENCY];

	// ------------------------------
	// Refresh scheduler
	// ------------------------------
	always_ff @(posedge clk) begin
		if (rst)
			ff_ref_cnt <= '0;
		else if (ff_ref_cnt == RC_W'(REFRESH_PERIOD - 1))
			ff_ref_cnt <= '0;
		else
			ff_ref_cnt <= ff_ref_cnt + 1'b1;
	end

	// Window sits at the head of each period
	assign refresh_active = ff_ref_cnt < RC_W'(REFRESH_LEN);

	// Head starts the cycle after it is queued
	assign start = ff_count != 2'd0 && !refresh_active;

	// ------------------------------
	// Request queue
	// ------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			ff_wr_ptr <= 1'b0;
			ff_rd_ptr <= 1'b0;
			ff_count <= 2'd0;
			ff_vpipe <= '0;
		end else begin
			if (req)
				ff_wr_ptr <= !ff_wr_ptr;
			if (start)
				ff_rd_ptr <= !ff_rd_ptr;
			ff_count <= ff_count + {1'b0, req} - {1'b0, start};
			// Only reads enter the delay line
			ff_vpipe <= {ff_vpipe[READ_LATENCY-2:0], start && !ff_q_we[ff_rd_ptr]};
		end
	end

	always_ff @(posedge clk) begin
		if (req) begin
			ff_q_we[ff_wr_ptr] <= req_we;
			ff_q_addr[ff_wr_ptr] <= req_addr;
			ff_q_wdata[ff_wr_ptr] <= req_wdata;
		end
	end

	// ------------------------------
	// Memory array
	// ------------------------------
	always_ff @(posedge clk) begin
		// Write completes at service
		if (start && ff_q_we[ff_rd_ptr])
			mem[ff_q_addr[ff_rd_ptr]] <= ff_q_wdata[ff_rd_ptr];
		ff_dpipe[0] <= mem[ff_q_addr[ff_rd_ptr]];
		for (int i = 1; i < READ_LATENCY; i++)
			ff_dpipe[i] <= ff_dpipe[i-1];
	end

	assign rd_valid = ff_vpipe[READ_LATENCY-1];
	assign rd_data = ff_dpipe[READ_LATENCY-1];

endmodule

`default_nettype wire

/* vdp_port.sv */
`default_nettype none

module vdp_port import cart_pkg::*; #(
	parameter int VRAM_AW = 14
) (
	input wire clk,
	input wire rst,
	input wire io_read,
	input wire io_write,
	input wire [1:0] port,
	input wire [7:0] wdata,
	input wire rd_valid,
	input wire [7:0] rd_data,
	output logic [7:0] rdata,
	output logic fetch_pending,
	output logic req,
	output logic req_we,
	output logic [VRAM_AW-1:0] req_addr,
	output logic [7:0] req_wdata
);

	localparam int RW = $clog2(NUM_REGS);

	logic [VRAM_AW-1:0] ff_addr;
	logic [7:0] ff_buf;
	logic [7:0] ff_latch;
	logic ff_flag;
	logic [7:0] ff_regs [NUM_REGS];
	logic [RW-1:0] ff_ptr;
	// Up to two prefetches in flight
	logic [1:0] ff_pend;
	// Port 0 read parked behind a prefetch
	logic ff_read_wait;

	logic data_rd, data_wr, ctrl_wr2, set_addr, set_fetch;
	logic busy_now, serve_rd, issue_rd;
	logic [7:0] ahead;
	logic [15:0] full_addr;
	logic [VRAM_AW-1:0] new_addr;

	// ------------------------------
	// Decode
	// ------------------------------
	assign data_rd = io_read && port == PORT_DATA;
	assign data_wr = io_write && port == PORT_DATA;
	// Second control byte
	assign ctrl_wr2 = io_write && port == PORT_CTRL && ff_flag;
	assign set_addr = ctrl_wr2 && !wdata[7];
	// Bit 6 clear marks a read setup
	assign set_fetch = set_addr && !wdata[6];
	assign full_addr = {2'b00, wdata[5:0], ff_latch};
	assign new_addr = full_addr[VRAM_AW-1:0];

	// Fresh data bypasses the buffer
	assign ahead = rd_valid ? rd_data : ff_buf;
	// Still waiting after this cycle's return
	assign busy_now = (ff_pend - {1'b0, rd_valid}) != 2'd0;
	// Immediate read, or a parked one once the last fetch lands
	assign serve_rd = (data_rd && !busy_now) ||
		(ff_read_wait && rd_valid && ff_pend == 2'd1);
	assign issue_rd = serve_rd || set_fetch;
	assign fetch_pending = ff_pend != 2'd0;

	// ------------------------------
	// VRAM requests and address
	// ------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			req <= 1'b0;
			ff_addr <= '0;
			ff_pend <= 2'd0;
			ff_read_wait <= 1'b0;
			ff_buf <= 8'h00;
		end else begin
			req <= data_wr || issue_rd;
			ff_pend <= ff_pend + {1'b0, issue_rd} - {1'b0, rd_valid};
			if (rd_valid)
				ff_buf <= rd_data;
			// Read setup leaves the pointer one past the fetch
			if (set_addr)
				ff_addr <= new_addr + VRAM_AW'(set_fetch);
			else if (data_wr || serve_rd)
				ff_addr <= ff_addr + 1'b1;
			if (data_rd && busy_now)
				ff_read_wait <= 1'b1;
			else if (serve_rd)
				ff_read_wait <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		req_we <= data_wr;
		req_wdata <= wdata;
		req_addr <= set_fetch ? new_addr : ff_addr;
	end

	// ------------------------------
	// Control latch, registers, readback
	// ------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			rdata <= 8'h00;
			ff_flag <= 1'b0;
			ff_ptr <= '0;
			for (int i = 0; i < NUM_REGS; i++)
				ff_regs[i] <= 8'h00;
		end else begin
			if (serve_rd)
				rdata <= ahead;
			// Any data port access resets the byte order
			if (data_rd || data_wr)
				ff_flag <= 1'b0;
			if (io_read && port == PORT_CTRL) begin
				rdata <= {7'b0, ff_flag};
				ff_flag <= 1'b0;
			end
			if (io_read && port == PORT_REGR)
				rdata <= ff_regs[ff_ptr];
			if (io_write && port == PORT_CTRL)
				ff_flag <= !ff_flag;
			// Register 7 is the pointer itself
			if (ctrl_wr2 && wdata[7]) begin
				if (wdata[2:0] == 3'd7)
					ff_ptr <= ff_latch[RW-1:0];
				else
					ff_regs[wdata[2:0]] <= ff_latch;
			end
			if (io_write && port == PORT_REGW) begin
				ff_regs[ff_ptr] <= wdata;
				ff_ptr <= ff_ptr + 1'b1;
			end
		end
	end

	// First control byte
	always_ff @(posedge clk) begin
		if (io_write && port == PORT_CTRL && !ff_flag)
			ff_latch <= wdata;
	end

endmodule

`default_nettype wire

/* msx_bus_if.sv */
`default_nettype none

module msx_bus_if import cart_pkg::*; (
	input wire clk,
	input wire rst,
	// Cartridge bus in the slow domain
	input wire n_ioreq,
	input wire n_rd,
	input wire n_wr,
	input wire [1:0] ta,
	input wire [7:0] td_in,
	// From the VDP port block
	input wire [7:0] rdata,
	input wire fetch_pending,
	// To the VDP port block
	output logic io_read,
	output logic io_write,
	output logic [1:0] port,
	output logic [7:0] wdata,
	// Back to the bus
	output logic [7:0] td_out,
	output logic tdir,
	output logic twait
);

	localparam int PW_W = $clog2(POWERUP_WAIT + 1);

	// Two-flop synchronizers on the idle-high strobes
	logic [1:0] ff_ioreq_s;
	logic [1:0] ff_rd_s;
	logic [1:0] ff_wr_s;
	// Address and data ride the same two stages
	logic [1:0] ff_ta_s [2];
	logic [7:0] ff_td_s [2];
	// One strobe per bus cycle
	logic ff_done;
	logic [PW_W-1:0] ff_pw_cnt;
	logic cyc_start;

	// ------------------------------
	// Synchronizer
	// ------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			ff_ioreq_s <= 2'b11;
			ff_rd_s <= 2'b11;
			ff_wr_s <= 2'b11;
		end else begin
			ff_ioreq_s <= {ff_ioreq_s[0], n_ioreq};
			ff_rd_s <= {ff_rd_s[0], n_rd};
			ff_wr_s <= {ff_wr_s[0], n_wr};
		end
	end

	// Address and data stages
	always_ff @(posedge clk) begin
		ff_ta_s[0] <= ta;
		ff_ta_s[1] <= ff_ta_s[0];
		ff_td_s[0] <= td_in;
		ff_td_s[1] <= ff_td_s[0];
	end

	// ------------------------------
	// Strobe generation
	// ------------------------------
	// I/O cycle seen on the synchronized side and not yet taken
	assign cyc_start = !ff_ioreq_s[1] && (!ff_rd_s[1] || !ff_wr_s[1]) && !ff_done;

	always_ff @(posedge clk) begin
		if (rst) begin
			io_read <= 1'b0;
			io_write <= 1'b0;
			ff_done <= 1'b0;
		end else begin
			// Read wins if both strobes show up together
			io_read <= cyc_start && !ff_rd_s[1];
			io_write <= cyc_start && ff_rd_s[1];
			if (cyc_start)
				ff_done <= 1'b1;
			else if (ff_ioreq_s[1])
				ff_done <= 1'b0;
		end
	end

	// Port and write data held until the next cycle starts
	always_ff @(posedge clk) begin
		if (cyc_start) begin
			port <= ff_ta_s[1];
			wdata <= ff_td_s[1];
		end
	end

	// ------------------------------
	// Power-up wait and read drive
	// ------------------------------
	always_ff @(posedge clk) begin
		if (rst)
			ff_pw_cnt <= '0;
		else if (ff_pw_cnt != PW_W'(POWERUP_WAIT))
			ff_pw_cnt <= ff_pw_cnt + 1'b1;
	end

	// Held off until the counter saturates, or while a fetch is in flight
	assign twait = (ff_pw_cnt != PW_W'(POWERUP_WAIT)) || fetch_pending;

	// Drive only while the CPU reads
	assign tdir = !ff_ioreq_s[1] && !ff_rd_s[1];
	assign td_out = tdir ? rdata : 8'h00;

endmodule

`default_nettype wire

/* cart_pkg.sv */
`default_nettype none

package cart_pkg;

	// ------------------------------
	// I/O port numbers on ta[1:0]
	// ------------------------------
	// VRAM data with auto-increment
	localparam logic [1:0] PORT_DATA = 2'd0;
	// Two-byte address or register set
	localparam logic [1:0] PORT_CTRL = 2'd1;
	// Indirect register write
	localparam logic [1:0] PORT_REGW = 2'd2;
	// Register readback at the pointer
	localparam logic [1:0] PORT_REGR = 2'd3;

	// ------------------------------
	// Register file and timing
	// ------------------------------
	// Control registers with a 3-bit index
	localparam int NUM_REGS = 8;
	// twait hold after reset release
	localparam int POWERUP_WAIT = 16;
	// Refresh window length in clk cycles
	localparam int REFRESH_LEN = 4;
	// Start of service to read data
	localparam int READ_LATENCY = 3;

endpackage

`default_nettype wire
